// File: include/loadUnit_cfg.svh
`ifndef LOAD_UNIT_CFG_SVH
`define LOAD_UNIT_CFG_SVH

// primary opcodes of the supported loads
`define LOAD_OP_LB  6'd32
`define LOAD_OP_LBU 6'd36
`define LOAD_OP_LH  6'd33
`define LOAD_OP_LHU 6'd37
`define LOAD_OP_LW  6'd35
`define LOAD_OP_LWL 6'd34
`define LOAD_OP_LWR 6'd38
`define LOAD_OP_LUI 6'd15

// APB address bus width
`define LOAD_APB_AW 32

`endif

// File: hw/loadPkg.sv
package loadPkg;

    // widths that carry a meaning
    typedef logic [31:0] wordT;     // data word, register or memory
    typedef logic [31:0] addrT;     // byte address
    typedef logic [5:0]  opcodeT;   // primary opcode, instr[31:26]
    typedef logic [1:0]  byteOffT;  // byte offset inside a word

    // decoded load kinds
    typedef enum logic [3:0] {
        opLb,
        opLbu,
        opLh,
        opLhu,
        opLw,
        opLwl,
        opLwr,
        opLui,
        opBad   // unknown opcode
    } loadOpT;

    // APB read requester
    typedef enum logic [1:0] {
        apbIdle,
        apbSetup,
        apbAccess
    } apbStateT;

    // single entry decode stage
    typedef enum logic {
        decEmpty,
        decFull
    } decStateT;

endpackage

// File: hw/loadReqIf.sv
`timescale 1ns/100ps

// decoded memory load, decoder to APB requester
interface loadReqIf;

    logic valid;
    logic ready;
    loadPkg::loadOpT op;
    loadPkg::addrT wordAddr;    // low two bits always zero
    loadPkg::byteOffT offset;
    loadPkg::wordT regWord;     // old destination value, for LWL/LWR

    modport src (
        output valid,
        output op,
        output wordAddr,
        output offset,
        output regWord,
        input  ready
    );

    modport dst (
        input  valid,
        input  op,
        input  wordAddr,
        input  offset,
        input  regWord,
        output ready
    );

endinterface

// File: hw/loadDecode.sv
`timescale 1ns/100ps
`include "loadUnit_cfg.svh"

module loadDecode (
    input  logic clk,
    input  logic arstN,
    input  logic reqValid,
    output logic reqReady,
    input  loadPkg::wordT reqInstr,
    input  loadPkg::addrT reqAddr,
    input  loadPkg::wordT reqRegWord,
    loadReqIf.src req,
    output logic bypassValid,
    output loadPkg::wordT bypassData,
    output logic bypassError,
    input  logic bypassTake
);

    loadPkg::decStateT state;
    loadPkg::wordT instrQ;
    loadPkg::addrT addrQ;
    loadPkg::wordT regWordQ;

    loadPkg::opcodeT opcode;
    loadPkg::loadOpT op;
    loadPkg::byteOffT offset;
    logic misaligned;
    logic isBad;
    logic isBypass;
    logic drain;

    assign opcode = instrQ[31:26];
    assign offset = addrQ[1:0];

    always_comb begin
        case (opcode)
            `LOAD_OP_LB:  op = loadPkg::opLb;
            `LOAD_OP_LBU: op = loadPkg::opLbu;
            `LOAD_OP_LH:  op = loadPkg::opLh;
            `LOAD_OP_LHU: op = loadPkg::opLhu;
            `LOAD_OP_LW:  op = loadPkg::opLw;
            `LOAD_OP_LWL: op = loadPkg::opLwl;
            `LOAD_OP_LWR: op = loadPkg::opLwr;
            `LOAD_OP_LUI: op = loadPkg::opLui;
            default:      op = loadPkg::opBad;
        endcase
    end

    // halfwords need an even offset, words offset 0
    always_comb begin
        case (op)
            loadPkg::opLh, loadPkg::opLhu: misaligned = offset[0];
            loadPkg::opLw:                 misaligned = (offset != 2'd0);
            default:                       misaligned = 1'b0;
        endcase
    end

    assign isBad    = (op == loadPkg::opBad) || misaligned;
    assign isBypass = isBad || (op == loadPkg::opLui);

    // bypass path, no memory access
    assign bypassValid = (state == loadPkg::decFull) && isBypass;
    assign bypassError = isBad;
    assign bypassData  = (op == loadPkg::opLui) ? {instrQ[15:0], 16'h0000} : '0;

    // memory loads go to the requester word aligned
    assign req.valid    = (state == loadPkg::decFull) && !isBypass;
    assign req.op       = op;
    assign req.wordAddr = {addrQ[31:2], 2'b00};
    assign req.offset   = offset;
    assign req.regWord  = regWordQ;

    assign drain    = (bypassValid && bypassTake) || (req.valid && req.ready);
    assign reqReady = (state == loadPkg::decEmpty) || drain;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= loadPkg::decEmpty;
        end else if (reqValid && reqReady) begin
            state <= loadPkg::decFull;
        end else if (drain) begin
            state <= loadPkg::decEmpty;
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid && reqReady) begin
            instrQ   <= reqInstr;
            addrQ    <= reqAddr;
            regWordQ <= reqRegWord;
        end
    end

    // the top level only takes a bypass result that is on offer
    assert property (@(posedge clk) disable iff (!arstN)
        bypassTake |-> bypassValid)
        else $error("bypass result taken while none was offered");

endmodule

// File: hw/apbLoadMaster.sv
`timescale 1ns/100ps
`include "loadUnit_cfg.svh"

module apbLoadMaster (
    input  logic clk,
    input  logic arstN,
    loadReqIf.dst req,
    output logic [`LOAD_APB_AW-1:0] paddr,
    output logic psel,
    output logic penable,
    input  loadPkg::wordT prdata,
    input  logic pready,
    input  logic pslverr,
    output logic rdValid,
    output loadPkg::wordT rdData,
    output logic rdErr,
    output loadPkg::loadOpT rdOp,
    output loadPkg::byteOffT rdOffset,
    output loadPkg::wordT rdRegWord,
    input  logic rdTake
);

    loadPkg::apbStateT state;
    logic heldQ;            // finished read waiting for rdTake
    logic done;
    logic xfer;

    logic [`LOAD_APB_AW-1:0] paddrQ;
    loadPkg::loadOpT opQ;
    loadPkg::byteOffT offsetQ;
    loadPkg::wordT regWordQ;
    loadPkg::wordT dataQ;
    logic errQ;

    // one read at a time, nothing new while a result is parked
    assign req.ready = (state == loadPkg::apbIdle) && !heldQ;
    assign xfer      = req.valid && req.ready;
    assign done      = (state == loadPkg::apbAccess) && pready;

    assign paddr   = paddrQ;
    assign psel    = (state != loadPkg::apbIdle);
    assign penable = (state == loadPkg::apbAccess);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= loadPkg::apbIdle;
        end else begin
            case (state)
                loadPkg::apbIdle:   if (xfer) state <= loadPkg::apbSetup;
                loadPkg::apbSetup:  state <= loadPkg::apbAccess;
                loadPkg::apbAccess: if (pready) state <= loadPkg::apbIdle;
                default:            state <= loadPkg::apbIdle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            heldQ <= 1'b0;
        end else if (done && !rdTake) begin
            heldQ <= 1'b1;
        end else if (rdTake) begin
            heldQ <= 1'b0;
        end
    end

    // operation fields at transfer, read data at completion
    always_ff @(posedge clk) begin
        if (xfer) begin
            paddrQ   <= req.wordAddr[`LOAD_APB_AW-1:0];
            opQ      <= req.op;
            offsetQ  <= req.offset;
            regWordQ <= req.regWord;
        end
        if (done) begin
            dataQ <= prdata;
            errQ  <= pslverr;
        end
    end

    // completing read is forwarded in its own cycle
    assign rdValid   = done || heldQ;
    assign rdData    = heldQ ? dataQ : prdata;
    assign rdErr     = heldQ ? errQ : pslverr;
    assign rdOp      = opQ;
    assign rdOffset  = offsetQ;
    assign rdRegWord = regWordQ;

    // decoder keeps its offer steady until the requester takes it
    assert property (@(posedge clk) disable iff (!arstN)
        req.valid && !req.ready |=> req.valid && $stable(req.wordAddr) && $stable(req.op))
        else $error("load request changed before it was accepted");

    assert property (@(posedge clk) disable iff (!arstN)
        psel |-> paddr[1:0] == 2'b00)
        else $error("APB read of an address that is not word aligned");

endmodule

// File: hw/loadAlign.sv
`timescale 1ns/100ps

module loadAlign (
    input  loadPkg::loadOpT op,
    input  loadPkg::byteOffT offset,
    input  loadPkg::wordT memWord,
    input  loadPkg::wordT regWord,
    output loadPkg::wordT result
);

    logic [7:0]  laneByte;
    logic [15:0] laneHalf;

    // little endian, lane k is bits 8k+7:8k
    assign laneByte = memWord[{offset, 3'b000} +: 8];
    assign laneHalf = memWord[{offset[1], 4'b0000} +: 16];

    always_comb begin
        case (op)
            loadPkg::opLb:  result = {{24{laneByte[7]}}, laneByte};
            loadPkg::opLbu: result = {24'h000000, laneByte};
            loadPkg::opLh:  result = {{16{laneHalf[15]}}, laneHalf};
            loadPkg::opLhu: result = {16'h0000, laneHalf};
            loadPkg::opLw:  result = memWord;

            // memory shifted down, register keeps its top bytes
            loadPkg::opLwr: begin
                case (offset)
                    2'd0:    result = memWord;
                    2'd1:    result = {regWord[31:24], memWord[31:8]};
                    2'd2:    result = {regWord[31:16], memWord[31:16]};
                    default: result = {regWord[31:8], memWord[31:24]};
                endcase
            end

            // low memory bytes to the top, register fills below
            loadPkg::opLwl: begin
                case (offset)
                    2'd0:    result = {memWord[7:0], regWord[23:0]};
                    2'd1:    result = {memWord[15:0], regWord[15:0]};
                    2'd2:    result = {memWord[23:0], regWord[7:0]};
                    default: result = memWord;
                endcase
            end

            default: result = '0;   // LUI and bad ops never come this way
        endcase
    end

endmodule

// File: hw/loadUnit.sv
`timescale 1ns/100ps
`include "loadUnit_cfg.svh"

module loadUnit (
    input  logic clk,
    input  logic arstN,
    input  logic reqValid,
    output logic reqReady,
    input  loadPkg::wordT reqInstr,
    input  loadPkg::addrT reqAddr,
    input  loadPkg::wordT reqRegWord,
    output logic rspValid,
    input  logic rspReady,
    output loadPkg::wordT rspData,
    output logic rspError,
    output logic [`LOAD_APB_AW-1:0] paddr,
    output logic psel,
    output logic penable,
    input  loadPkg::wordT prdata,
    input  logic pready,
    input  logic pslverr
);

    loadReqIf reqIf ();

    logic bypassValid;
    loadPkg::wordT bypassData;
    logic bypassError;
    logic bypassTake;

    logic rdValid;
    loadPkg::wordT rdData;
    logic rdErr;
    loadPkg::loadOpT rdOp;
    loadPkg::byteOffT rdOffset;
    loadPkg::wordT rdRegWord;
    logic rdTake;

    loadPkg::wordT alignResult;
    logic canLoad;

    loadDecode uDecode (
        .clk         (clk),
        .arstN       (arstN),
        .reqValid    (reqValid),
        .reqReady    (reqReady),
        .reqInstr    (reqInstr),
        .reqAddr     (reqAddr),
        .reqRegWord  (reqRegWord),
        .req         (reqIf.src),
        .bypassValid (bypassValid),
        .bypassData  (bypassData),
        .bypassError (bypassError),
        .bypassTake  (bypassTake)
    );

    apbLoadMaster uApb (
        .clk       (clk),
        .arstN     (arstN),
        .req       (reqIf.dst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .rdValid   (rdValid),
        .rdData    (rdData),
        .rdErr     (rdErr),
        .rdOp      (rdOp),
        .rdOffset  (rdOffset),
        .rdRegWord (rdRegWord),
        .rdTake    (rdTake)
    );

    loadAlign uAlign (
        .op      (rdOp),
        .offset  (rdOffset),
        .memWord (rdData),
        .regWord (rdRegWord),
        .result  (alignResult)
    );

    assign canLoad = !rspValid || rspReady;
    assign rdTake  = rdValid && canLoad;
    // requester idle and empty means the bypass entry is the oldest
    assign bypassTake = bypassValid && canLoad && reqIf.ready;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rspValid <= 1'b0;
        end else if (rdTake || bypassTake) begin
            rspValid <= 1'b1;
        end else if (rspReady) begin
            rspValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rdTake) begin
            rspData  <= rdErr ? '0 : alignResult;   // slave error zeroes data
            rspError <= rdErr;
        end else if (bypassTake) begin
            rspData  <= bypassData;
            rspError <= bypassError;
        end
    end

    // a finished memory load is older than any waiting bypass result
    assert property (@(posedge clk) disable iff (!arstN)
        rdValid |-> !bypassTake)
        else $error("bypass result overtook an older memory load");

endmodule

// File: tests/tbClock.sv
`timescale 1ns/100ps

module tbClock #(
    parameter int PERIOD = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;   // release away from the rising edge
    end

endmodule

// File: tests/loadUnitTb.sv
`timescale 1ns/100ps
`include "loadUnit_cfg.svh"

module loadUnitTb;

    localparam int clkPeriod = 20;
    localparam int numReqs = 100;        // directed plus random requests below
    localparam int maxLoadCycles = 40;   // generous bound for one load under stalls
    localparam int timeoutNs = (numReqs * maxLoadCycles + 50) * clkPeriod;

    logic clk;
    logic arstN;
    logic reqValid;
    logic reqReady;
    loadPkg::wordT reqInstr;
    loadPkg::addrT reqAddr;
    loadPkg::wordT reqRegWord;
    logic rspValid;
    logic rspReady;
    loadPkg::wordT rspData;
    logic rspError;
    logic [`LOAD_APB_AW-1:0] paddr;
    logic psel;
    logic penable;
    loadPkg::wordT prdata;
    logic pready;
    logic pslverr;

    logic [15:0] lfsrState;
    int rspMode;                // 0 always ready, 1 random, 2 held low
    int mismatchCount;
    int otherCount;
    int reqCount;
    int rspCount;

    // expected responses in request order, APB word addresses in issue order
    loadPkg::wordT expDataQ[$];
    logic expErrQ[$];
    loadPkg::addrT apbAddrQ[$];
    logic expPending;
    loadPkg::wordT expData;
    logic expErr;
    logic apbPending;
    loadPkg::addrT apbAddr;

    tbClock #(.PERIOD(clkPeriod), .RESET_CYCLES(10)) uClock (.clk(clk), .arstN(arstN));

    loadUnit dut (
        .clk(clk), .arstN(arstN),
        .reqValid(reqValid), .reqReady(reqReady), .reqInstr(reqInstr),
        .reqAddr(reqAddr), .reqRegWord(reqRegWord),
        .rspValid(rspValid), .rspReady(rspReady), .rspData(rspData), .rspError(rspError),
        .paddr(paddr), .psel(psel), .penable(penable),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    // x^16 + x^14 + x^13 + x^11
    function automatic logic nextBit();
        logic fb;
        fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) v = {v[30:0], nextBit()};
        return v;
    endfunction

    function automatic loadPkg::wordT memWord(input loadPkg::addrT a);
        return (a ^ 32'h5EED_1234) * 32'h9E37_79B1 + {a[15:0], a[31:16]};
    endfunction

    function automatic logic isErrAddr(input loadPkg::addrT a);
        return a[31:24] == 8'hEE;   // slave error region
    endfunction

    // expected {error, data} from the byte order rules
    function automatic logic [32:0] modelLoad(input loadPkg::wordT instr,
            input loadPkg::addrT addr, input loadPkg::wordT regWord, output logic usesApb);
        logic [5:0] opc;
        loadPkg::wordT mem;
        loadPkg::wordT shifted;
        loadPkg::wordT r;
        logic err;
        int sh;
        opc = instr[31:26];
        sh = 8 * addr[1:0];
        mem = memWord({addr[31:2], 2'b00});
        shifted = mem >> sh;
        usesApb = 1'b1;
        err = 1'b0;
        r = '0;
        case (opc)
            `LOAD_OP_LB:  r = {{24{shifted[7]}}, shifted[7:0]};
            `LOAD_OP_LBU: r = {24'h000000, shifted[7:0]};
            `LOAD_OP_LH:  r = {{16{shifted[15]}}, shifted[15:0]};
            `LOAD_OP_LHU: r = {16'h0000, shifted[15:0]};
            `LOAD_OP_LW:  r = mem;
            `LOAD_OP_LWR: r = shifted | (regWord & ~(32'hFFFF_FFFF >> sh));
            `LOAD_OP_LWL: r = (mem << (24 - sh)) | (regWord & (32'hFFFF_FFFF >> (sh + 8)));
            `LOAD_OP_LUI: begin
                r = {instr[15:0], 16'h0000};
                usesApb = 1'b0;
            end
            default: err = 1'b1;
        endcase
        if ((opc == `LOAD_OP_LH || opc == `LOAD_OP_LHU) && addr[0]) err = 1'b1;
        if (opc == `LOAD_OP_LW && addr[1:0] != 2'b00) err = 1'b1;
        if (err) usesApb = 1'b0;         // decode errors never reach the bus
        if (usesApb && isErrAddr(addr)) err = 1'b1;
        if (err) r = '0;
        return {err, r};
    endfunction

    function automatic logic [5:0] opcodeFor(input int i);
        case (i)
            0: return `LOAD_OP_LB;
            1: return `LOAD_OP_LBU;
            2: return `LOAD_OP_LH;
            3: return `LOAD_OP_LHU;
            4: return `LOAD_OP_LW;
            5: return `LOAD_OP_LWL;
            default: return `LOAD_OP_LWR;
        endcase
    endfunction

    function automatic loadPkg::wordT makeInstr(input logic [5:0] opc);
        loadPkg::wordT w;
        w = randBits(32);
        w[31:26] = opc;
        return w;
    endfunction

    function automatic loadPkg::addrT addrWithOff(input logic [1:0] k);
        loadPkg::addrT a;
        a = randBits(32);
        a[1:0] = k;
        if (isErrAddr(a)) a[31:24] = 8'h00;   // keep directed loads error free
        return a;
    endfunction

    task automatic sendReq(input loadPkg::wordT instr, input loadPkg::addrT addr,
            input loadPkg::wordT regWord);
        @(negedge clk);
        reqValid = 1'b1;
        reqInstr = instr;
        reqAddr = addr;
        reqRegWord = regWord;
        @(posedge clk);
        while (!reqReady) @(posedge clk);
    endtask

    task automatic idleReq();
        @(negedge clk);
        reqValid = 1'b0;
        @(posedge clk);
    endtask

    initial begin
        lfsrState = 16'd45925;
        rspMode = 0;
        reqValid = 1'b0;
        reqInstr = '0;
        reqAddr = '0;
        reqRegWord = '0;
        rspReady = 1'b1;
        prdata = '0;
        pready = 1'b0;
        pslverr = 1'b0;
    end

    // APB memory with random wait states, and the response sink
    always @(negedge clk) begin
        if (psel && penable) begin
            pready = (randBits(2) != 2'd0);
            prdata = memWord(paddr);
            pslverr = pready && isErrAddr(paddr);
        end else begin
            pready = 1'b0;
            pslverr = 1'b0;
            prdata = '0;
        end
        case (rspMode)
            0: rspReady = 1'b1;
            1: rspReady = nextBit();
            default: rspReady = 1'b0;
        endcase
    end

    always @(posedge clk) begin
        logic [32:0] m;
        logic viaApb;
        if (arstN) begin
            if (rspValid && rspReady) begin
                rspCount++;
                if (expDataQ.size() > 0) begin
                    void'(expDataQ.pop_front());
                    void'(expErrQ.pop_front());
                end
            end
            if (psel && penable && pready && apbAddrQ.size() > 0) void'(apbAddrQ.pop_front());
            if (reqValid && reqReady) begin
                m = modelLoad(reqInstr, reqAddr, reqRegWord, viaApb);
                expDataQ.push_back(m[31:0]);
                expErrQ.push_back(m[32]);
                if (viaApb) apbAddrQ.push_back({reqAddr[31:2], 2'b00});
                reqCount++;
            end
            expPending = (expDataQ.size() > 0);
            expData = expPending ? expDataQ[0] : '0;
            expErr = expPending ? expErrQ[0] : 1'b0;
            apbPending = (apbAddrQ.size() > 0);
            apbAddr = apbPending ? apbAddrQ[0] : '0;
        end
    end

    assert property (@(posedge clk) disable iff (!arstN) rspValid |-> expPending)
        else begin
            otherCount++;
            $display("Response arrived with no request outstanding");
        end

    assert property (@(posedge clk) disable iff (!arstN)
        rspValid && expPending |-> rspData == expData)
        else begin
            mismatchCount++;
            $display("Mismatch rspData: expected %h, actual %h",
                $sampled(expData), $sampled(rspData));
        end

    assert property (@(posedge clk) disable iff (!arstN)
        rspValid && expPending |-> rspError == expErr)
        else begin
            mismatchCount++;
            $display("Mismatch rspError: expected %h, actual %h",
                $sampled(expErr), $sampled(rspError));
        end

    // held response under back-pressure
    assert property (@(posedge clk) disable iff (!arstN)
        rspValid && !rspReady |=> rspValid && $stable(rspData) && $stable(rspError))
        else begin
            otherCount++;
            $display("Response dropped or changed while rspReady was low");
        end

    // previous cycle is a setup or a waited access, never a finished one
    assert property (@(posedge clk) disable iff (!arstN)
        penable |-> psel && $past(psel) && !$past(penable && pready))
        else begin
            otherCount++;
            $display("APB penable raised without a setup cycle");
        end

    assert property (@(posedge clk) disable iff (!arstN) psel |-> apbPending)
        else begin
            otherCount++;
            $display("APB read started with no memory load outstanding");
        end

    assert property (@(posedge clk) disable iff (!arstN)
        psel && apbPending |-> paddr == apbAddr)
        else begin
            mismatchCount++;
            $display("Mismatch paddr: expected %h, actual %h", $sampled(apbAddr), $sampled(paddr));
        end

    initial begin
        #(timeoutNs);
        $display("Watchdog expired after %0d ns with %0d of %0d responses",
            timeoutNs, rspCount, reqCount);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int opIdx;
        int k;
        int sel;
        logic [5:0] opc;
        loadPkg::addrT addr;
        mismatchCount = 0;
        otherCount = 0;
        reqCount = 0;
        rspCount = 0;
        wait (arstN === 1'b1);
        @(negedge clk);
        if (reqReady !== 1'b1 || rspValid !== 1'b0 || psel !== 1'b0 || penable !== 1'b0) begin
            otherCount++;
            $display("Outputs not in their reset state after reset release");
        end
        @(posedge clk);

        // every memory load kind at every offset
        for (opIdx = 0; opIdx < 7; opIdx++) begin
            for (k = 0; k < 4; k++) begin
                sendReq(makeInstr(opcodeFor(opIdx)), addrWithOff(k), randBits(32));
            end
        end

        // bypass cases, then slave errors
        sendReq(makeInstr(`LOAD_OP_LUI), randBits(32), randBits(32));
        sendReq(makeInstr(`LOAD_OP_LUI), randBits(32), randBits(32));
        sendReq(makeInstr(6'd43), addrWithOff(0), randBits(32));   // store opcode
        sendReq(makeInstr(6'd0), addrWithOff(2), randBits(32));
        sendReq(makeInstr(`LOAD_OP_LH), addrWithOff(1), randBits(32));
        sendReq(makeInstr(`LOAD_OP_LHU), addrWithOff(3), randBits(32));
        sendReq(makeInstr(`LOAD_OP_LW), addrWithOff(2), randBits(32));
        sendReq(makeInstr(`LOAD_OP_LW), 32'hEE00_1230, randBits(32));
        sendReq(makeInstr(`LOAD_OP_LB), 32'hEE01_0013, randBits(32));
        idleReq();

        // stall from an empty pipeline so all three loads find room
        while (expDataQ.size() != 0) @(posedge clk);

        // fill the pipeline with the sink stalled
        rspMode = 2;
        for (k = 0; k < 3; k++) begin
            sendReq(makeInstr(`LOAD_OP_LW), addrWithOff(0), randBits(32));
        end
        idleReq();
        repeat (12) @(posedge clk);

        rspMode = 1;
        for (k = 0; k < 60; k++) begin
            sel = randBits(4);
            if (sel < 7) opc = opcodeFor(sel);
            else if (sel < 9) opc = `LOAD_OP_LUI;
            else if (sel == 9) opc = 6'd43;
            else opc = opcodeFor(sel - 10);
            addr = randBits(32);
            if (randBits(4) == 0) addr[31:24] = 8'hEE;
            sendReq(makeInstr(opc), addr, randBits(32));
        end
        idleReq();
        rspMode = 0;

        while (expDataQ.size() != 0) @(posedge clk);
        repeat (5) @(posedge clk);
        if (rspCount != reqCount) begin
            otherCount++;
            $display("Lost responses: %0d requests but %0d responses", reqCount, rspCount);
        end
        $display("Summary: %0d requests, %0d responses, %0d mismatches, %0d other errors",
            reqCount, rspCount, mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: loadUnit.f
+incdir+include
hw/loadPkg.sv
hw/loadReqIf.sv
hw/loadDecode.sv
hw/apbLoadMaster.sv
hw/loadAlign.sv
hw/loadUnit.sv
tests/tbClock.sv
tests/loadUnitTb.sv
